// File: hw/fpmul_settings.svh
// widths fixed for single precision; changing them needs matching package and bench updates
`ifndef FPMUL_SETTINGS_SVH
`define FPMUL_SETTINGS_SVH

// fraction with hidden bit shown
`define FPMUL_FRACT_W 24
// extended exponent, two's complement range for under/overflow
`define FPMUL_EXP_W 10
`define FPMUL_BIAS 127

// multiplier split into 16-bit halves
`define FPMUL_HALF_W 16
`define FPMUL_MUL_W (2 * `FPMUL_HALF_W)
`define FPMUL_PROD_W 48

// right shift saturates at 31
`define FPMUL_SHR_W 5
// 27 product bits plus sticky
`define FPMUL_OUT_W 28

`endif

// File: hw/fp_format_pkg.sv
// unpacked operand format only; NaN detection and packing live outside this pipeline
`default_nettype none

`include "fpmul_settings.svh"

package fp_format_pkg;

  typedef logic [`FPMUL_FRACT_W-1:0] fract_t;
  typedef logic [`FPMUL_EXP_W-1:0]   exp_t;
  typedef logic [`FPMUL_SHR_W-1:0]   shr_t;

  // bits 27..1 product, bit 0 sticky
  typedef logic [`FPMUL_OUT_W-1:0]   fract_out_t;

  // one unpacked operand
  typedef struct packed {
    logic   sign;
    exp_t   exp;
    // hidden bit at msb, may be denormal
    fract_t fract;
    logic   inf;
    logic   zero;
  } operand_t;

endpackage

`default_nettype wire

// File: hw/fpmul_pipe_pkg.sv
// payloads passed between stages; flag meanings follow the caller's NaN/inf classification
`default_nettype none

`include "fpmul_settings.svh"

package fpmul_pipe_pkg;

  import fp_format_pkg::*;

  // exception and NaN info, carried alongside the data
  typedef struct packed {
    logic inv;
    logic inf;
    logic snan;
    logic qnan;
    logic anan_sign;
  } exc_flags_t;

  // right-shift decision for the later align stage
  typedef struct packed {
    shr_t shr;
    exp_t exp10shr;
    exp_t exp10sh0;
  } shr_info_t;

endpackage

`default_nettype wire

// File: hw/fpmul_prod_if.sv
// stage-1 results only; no handshake, qualified by valid and moved by the shared advance strobe
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

interface fpmul_prod_if
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
();

  logic                    valid;
  // force-zero from a zero operand
  logic                    opc_0;
  logic                    signc;
  // biased exponent sum, already masked
  exp_t                    exp10c;
  // normalized fractions with 8 zeros appended
  logic [`FPMUL_MUL_W-1:0] mul_a;
  logic [`FPMUL_MUL_W-1:0] mul_b;
  exc_flags_t              flags;

  modport prep (output valid, opc_0, signc, exp10c, mul_a, mul_b, flags);
  modport prod (input valid, opc_0, signc, exp10c, mul_a, mul_b, flags);

endinterface

`default_nettype wire

// File: hw/fpmul_lzc.sv
// pure combinational count; an all-zero fraction reports 0, callers flag zero separately
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_lzc
  import fp_format_pkg::*;
(
  input  fract_t fract_i,
  output shr_t   nlz_o
);

  // scan lsb to msb, highest set bit wins
  always_comb begin
    nlz_o = '0;
    for (int i = 0; i < `FPMUL_FRACT_W; i++) begin
      if (fract_i[i]) begin
        nlz_o = shr_t'(`FPMUL_FRACT_W - 1 - i);
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/fpmul_stage_reg.sv
// payload has no reset and is only meaningful while valid_o is high
`timescale 1ns/100ps
`default_nettype none

module fpmul_stage_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     adv_i,
  input  logic     flush_i,
  input  logic     valid_i,
  input  payload_t data_i,
  output logic     valid_o,
  output payload_t data_o
);

  // valid: flush wins over advance
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      valid_o <= 1'b0;
    end else if (flush_i) begin
      valid_o <= 1'b0;
    end else if (adv_i) begin
      valid_o <= valid_i;
    end
  end

  // data moves only on advance
  always_ff @(posedge clk) begin
    if (adv_i) begin
      data_o <= data_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpmul_operand_prep.sv
// stages 0 and 1; operands must already be unpacked, exponent sum wraps in 10 bits
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_operand_prep
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
(
  input  logic          clk,
  input  logic          rst,
  input  logic          adv_i,
  input  logic          flush_i,
  input  logic          start_i,
  input  operand_t      opa_i,
  input  operand_t      opb_i,
  input  logic          snan_i,
  input  logic          qnan_i,
  input  logic          anan_sign_i,
  fpmul_prod_if.prep    prod_o
);

  localparam int PAD_W = `FPMUL_MUL_W - `FPMUL_FRACT_W;

  ////////////////////////////////////////////////////////////////////////////
  // stage 0: classify and count
  ////////////////////////////////////////////////////////////////////////////

  exc_flags_t s0t_flags;
  exc_flags_t s0o_flags;
  logic       s0o_valid;
  shr_t       s0t_nlza;
  shr_t       s0t_nlzb;

  logic       s0o_opc_0;
  logic       s0o_signc;
  shr_t       s0o_nlza;
  shr_t       s0o_nlzb;
  exp_t       s0o_expa;
  exp_t       s0o_expb;
  fract_t     s0o_fracta;
  fract_t     s0o_fractb;

  fpmul_lzc i_lzc_a (.fract_i(opa_i.fract), .nlz_o(s0t_nlza));
  fpmul_lzc i_lzc_b (.fract_i(opb_i.fract), .nlz_o(s0t_nlzb));

  // 0 * inf is invalid, any inf gives inf
  assign s0t_flags = '{
    inv:       (opa_i.zero & opb_i.inf) | (opb_i.zero & opa_i.inf),
    inf:       opa_i.inf | opb_i.inf,
    snan:      snan_i,
    qnan:      qnan_i,
    anan_sign: anan_sign_i
  };

  fpmul_stage_reg #(.payload_t(exc_flags_t)) i_flags_s0 (
    .clk     (clk),
    .rst     (rst),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .valid_i (start_i),
    .data_i  (s0t_flags),
    .valid_o (s0o_valid),
    .data_o  (s0o_flags)
  );

  always_ff @(posedge clk) begin
    if (adv_i) begin
      s0o_opc_0  <= opa_i.zero | opb_i.zero;
      s0o_signc  <= opa_i.sign ^ opb_i.sign;
      s0o_nlza   <= s0t_nlza;
      s0o_nlzb   <= s0t_nlzb;
      s0o_expa   <= opa_i.exp;
      s0o_expb   <= opb_i.exp;
      s0o_fracta <= opa_i.fract;
      s0o_fractb <= opb_i.fract;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stage 1: normalize, exponent sum
  ////////////////////////////////////////////////////////////////////////////

  fract_t s1t_fracta;
  fract_t s1t_fractb;
  exp_t   s1t_exp10;

  // zero operand wipes both fractions and the sum
  assign s1t_fracta = (s0o_fracta << s0o_nlza) & {`FPMUL_FRACT_W{~s0o_opc_0}};
  assign s1t_fractb = (s0o_fractb << s0o_nlzb) & {`FPMUL_FRACT_W{~s0o_opc_0}};
  assign s1t_exp10  = (s0o_expa - exp_t'(s0o_nlza) + s0o_expb - exp_t'(s0o_nlzb)
                      - exp_t'(`FPMUL_BIAS)) & {`FPMUL_EXP_W{~s0o_opc_0}};

  fpmul_stage_reg #(.payload_t(exc_flags_t)) i_flags_s1 (
    .clk     (clk),
    .rst     (rst),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .valid_i (s0o_valid),
    .data_i  (s0o_flags),
    .valid_o (prod_o.valid),
    .data_o  (prod_o.flags)
  );

  always_ff @(posedge clk) begin
    if (adv_i) begin
      prod_o.opc_0  <= s0o_opc_0;
      prod_o.signc  <= s0o_signc;
      prod_o.exp10c <= s1t_exp10;
      prod_o.mul_a  <= {s1t_fracta, {PAD_W{1'b0}}};
      prod_o.mul_b  <= {s1t_fractb, {PAD_W{1'b0}}};
    end
  end

endmodule

`default_nettype wire

// File: hw/fpmul_product.sv
// stage 2; partial products are unsigned 16x16, shift saturates at 31 for deep underflow
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_product
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
(
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       adv_i,
  input  logic                                       flush_i,
  fpmul_prod_if.prod                                 prod_i,
  output logic                                       valid_o,
  output logic                                       signc_o,
  output logic [3:0][`FPMUL_MUL_W-1:0]               pp_o,
  output shr_info_t                                  shr_o,
  output exc_flags_t                                 flags_o
);

  ////////////////////////////////////////////////////////////////////////////
  // right-shift decision
  ////////////////////////////////////////////////////////////////////////////

  logic      exp_zero;
  exp_t      shr_neg;
  exp_t      shr_wide;
  shr_info_t shr_next;

  assign exp_zero = ~(|prod_i.exp10c);
  // 1025 - sum for a negative sum
  assign shr_neg  = exp_t'(11'd1025 - {1'b0, prod_i.exp10c});

  always_comb begin
    shr_next.exp10sh0 = prod_i.exp10c;
    if (prod_i.opc_0) begin
      shr_wide          = '0;
      shr_next.exp10shr = '0;
    end else if (prod_i.exp10c[`FPMUL_EXP_W-1]) begin
      shr_wide          = shr_neg;
      shr_next.exp10shr = exp_t'(1);
    end else begin
      // zero sum: shift by one, exponent becomes 1
      shr_wide          = exp_t'(exp_zero);
      shr_next.exp10shr = prod_i.exp10c | exp_t'(exp_zero);
    end
    // any upper bit set saturates to 31
    shr_next.shr = shr_wide[`FPMUL_SHR_W-1:0] | {`FPMUL_SHR_W{|shr_wide[`FPMUL_EXP_W-1:`FPMUL_SHR_W]}};
  end

  fpmul_stage_reg #(.payload_t(exc_flags_t)) i_flags_s2 (
    .clk     (clk),
    .rst     (rst),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .valid_i (prod_i.valid),
    .data_i  (prod_i.flags),
    .valid_o (valid_o),
    .data_o  (flags_o)
  );

  // same valid as the flags register
  fpmul_stage_reg #(.payload_t(shr_info_t)) i_shr_s2 (
    .clk     (clk),
    .rst     (rst),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .valid_i (prod_i.valid),
    .data_i  (shr_next),
    .valid_o (),
    .data_o  (shr_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // partial products: [0] al*bl, [1] al*bh, [2] ah*bl, [3] ah*bh
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (adv_i) begin
      signc_o <= prod_i.signc;
      pp_o[0] <= prod_i.mul_a[`FPMUL_HALF_W-1:0] * prod_i.mul_b[`FPMUL_HALF_W-1:0];
      pp_o[1] <= prod_i.mul_a[`FPMUL_HALF_W-1:0] * prod_i.mul_b[`FPMUL_MUL_W-1:`FPMUL_HALF_W];
      pp_o[2] <= prod_i.mul_a[`FPMUL_MUL_W-1:`FPMUL_HALF_W] * prod_i.mul_b[`FPMUL_HALF_W-1:0];
      pp_o[3] <= prod_i.mul_a[`FPMUL_MUL_W-1:`FPMUL_HALF_W]
                 * prod_i.mul_b[`FPMUL_MUL_W-1:`FPMUL_HALF_W];
    end
  end

endmodule

`default_nettype wire

// File: hw/fpmul_align_out.sv
// stage 3; output fraction is unrounded, rounding and final align happen downstream
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_align_out
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,
  input  logic                         adv_i,
  input  logic                         flush_i,
  input  logic                         valid_i,
  input  logic                         signc_i,
  input  logic [3:0][`FPMUL_MUL_W-1:0] pp_i,
  input  shr_info_t                    shr_i,
  input  exc_flags_t                   flags_i,
  output logic                         muldiv_rdy_o,
  output logic                         muldiv_sign_o,
  output shr_t                         muldiv_shr_o,
  output exp_t                         muldiv_exp10shr_o,
  output exp_t                         muldiv_exp10sh0_o,
  output fract_out_t                   muldiv_fract28_o,
  output logic                         muldiv_inv_o,
  output logic                         muldiv_inf_o,
  output logic                         muldiv_snan_o,
  output logic                         muldiv_qnan_o,
  output logic                         muldiv_anan_sign_o
);

  localparam int STK_HI = `FPMUL_PROD_W - `FPMUL_OUT_W;

  ////////////////////////////////////////////////////////////////////////////
  // product sum, upper 48 of the 64-bit result
  ////////////////////////////////////////////////////////////////////////////

  logic [`FPMUL_PROD_W-1:0] fract48;
  logic                     sticky;

  // appended zeros make this the exact 24x24 product
  assign fract48 = {pp_i[3], {`FPMUL_HALF_W{1'b0}}}
                 + {{`FPMUL_HALF_W{1'b0}}, pp_i[2]}
                 + {{`FPMUL_HALF_W{1'b0}}, pp_i[1]}
                 + {{`FPMUL_MUL_W{1'b0}}, pp_i[0][`FPMUL_MUL_W-1:`FPMUL_HALF_W]};

  // everything below bit 21 of the product
  assign sticky = |fract48[STK_HI:0];

  // output payload
  always_ff @(posedge clk) begin
    if (adv_i) begin
      muldiv_sign_o      <= signc_i;
      muldiv_shr_o       <= shr_i.shr;
      muldiv_exp10shr_o  <= shr_i.exp10shr;
      muldiv_exp10sh0_o  <= shr_i.exp10sh0;
      muldiv_fract28_o   <= {fract48[`FPMUL_PROD_W-1:STK_HI+1], sticky};
      muldiv_inv_o       <= flags_i.inv;
      muldiv_inf_o       <= flags_i.inf;
      muldiv_snan_o      <= flags_i.snan;
      muldiv_qnan_o      <= flags_i.qnan;
      muldiv_anan_sign_o <= flags_i.anan_sign;
    end
  end

  // ready pulse, one per valid result
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      muldiv_rdy_o <= 1'b0;
    end else if (flush_i) begin
      muldiv_rdy_o <= 1'b0;
    end else if (adv_i) begin
      muldiv_rdy_o <= valid_i;
    end
  end

endmodule

`default_nettype wire

// File: hw/fpmul_top.sv
// multiply only, 4-cycle latency at full advance; adv_i low stalls all stages, flush drops all
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_top
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      adv_i,
  input  logic                      flush_i,
  input  logic                      start_i,
  // operand a
  input  logic                      signa_i,
  input  logic [`FPMUL_EXP_W-1:0]   exp10a_i,
  input  logic [`FPMUL_FRACT_W-1:0] fract24a_i,
  input  logic                      infa_i,
  input  logic                      zeroa_i,
  // operand b
  input  logic                      signb_i,
  input  logic [`FPMUL_EXP_W-1:0]   exp10b_i,
  input  logic [`FPMUL_FRACT_W-1:0] fract24b_i,
  input  logic                      infb_i,
  input  logic                      zerob_i,
  // NaN info from the unpacker
  input  logic                      snan_i,
  input  logic                      qnan_i,
  input  logic                      anan_sign_i,
  output logic                      muldiv_rdy_o,
  output logic                      muldiv_sign_o,
  output logic [`FPMUL_SHR_W-1:0]   muldiv_shr_o,
  output logic [`FPMUL_EXP_W-1:0]   muldiv_exp10shr_o,
  output logic [`FPMUL_EXP_W-1:0]   muldiv_exp10sh0_o,
  output logic [`FPMUL_OUT_W-1:0]   muldiv_fract28_o,
  output logic                      muldiv_inv_o,
  output logic                      muldiv_inf_o,
  output logic                      muldiv_snan_o,
  output logic                      muldiv_qnan_o,
  output logic                      muldiv_anan_sign_o
);

  operand_t                     opa;
  operand_t                     opb;
  // stage 2 bundle
  logic                         s2_valid;
  logic                         s2_signc;
  logic [3:0][`FPMUL_MUL_W-1:0] s2_pp;
  shr_info_t                    s2_shr;
  exc_flags_t                   s2_flags;

  fpmul_prod_if i_prod_if ();

  assign opa = '{sign: signa_i, exp: exp10a_i, fract: fract24a_i, inf: infa_i, zero: zeroa_i};
  assign opb = '{sign: signb_i, exp: exp10b_i, fract: fract24b_i, inf: infb_i, zero: zerob_i};

  fpmul_operand_prep i_operand_prep (
    .clk         (clk),
    .rst         (rst),
    .adv_i       (adv_i),
    .flush_i     (flush_i),
    .start_i     (start_i),
    .opa_i       (opa),
    .opb_i       (opb),
    .snan_i      (snan_i),
    .qnan_i      (qnan_i),
    .anan_sign_i (anan_sign_i),
    .prod_o      (i_prod_if.prep)
  );

  fpmul_product i_product (
    .clk     (clk),
    .rst     (rst),
    .adv_i   (adv_i),
    .flush_i (flush_i),
    .prod_i  (i_prod_if.prod),
    .valid_o (s2_valid),
    .signc_o (s2_signc),
    .pp_o    (s2_pp),
    .shr_o   (s2_shr),
    .flags_o (s2_flags)
  );

  fpmul_align_out i_align_out (
    .clk                (clk),
    .rst                (rst),
    .adv_i              (adv_i),
    .flush_i            (flush_i),
    .valid_i            (s2_valid),
    .signc_i            (s2_signc),
    .pp_i               (s2_pp),
    .shr_i              (s2_shr),
    .flags_i            (s2_flags),
    .muldiv_rdy_o       (muldiv_rdy_o),
    .muldiv_sign_o      (muldiv_sign_o),
    .muldiv_shr_o       (muldiv_shr_o),
    .muldiv_exp10shr_o  (muldiv_exp10shr_o),
    .muldiv_exp10sh0_o  (muldiv_exp10sh0_o),
    .muldiv_fract28_o   (muldiv_fract28_o),
    .muldiv_inv_o       (muldiv_inv_o),
    .muldiv_inf_o       (muldiv_inf_o),
    .muldiv_snan_o      (muldiv_snan_o),
    .muldiv_qnan_o      (muldiv_qnan_o),
    .muldiv_anan_sign_o (muldiv_anan_sign_o)
  );

endmodule

`default_nettype wire

// File: bench/fpmul_props.sv
// checks control timing only (ready, flush, stall); data values are checked by the testbench
`timescale 1ns/100ps
`default_nettype none

module fpmul_props
  import fp_format_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  input  logic       adv_i,
  input  logic       flush_i,
  input  logic       start_i,
  input  logic       muldiv_rdy_o,
  input  logic       muldiv_sign_o,
  input  shr_t       muldiv_shr_o,
  input  exp_t       muldiv_exp10shr_o,
  input  exp_t       muldiv_exp10sh0_o,
  input  fract_out_t muldiv_fract28_o,
  input  logic       muldiv_inv_o,
  input  logic       muldiv_inf_o,
  input  logic       muldiv_snan_o,
  input  logic       muldiv_qnan_o,
  input  logic       muldiv_anan_sign_o
);

  // all registered outputs in one vector
  logic [59:0] out_bus;

  assign out_bus = {muldiv_rdy_o, muldiv_sign_o, muldiv_shr_o, muldiv_exp10shr_o,
                    muldiv_exp10sh0_o, muldiv_fract28_o, muldiv_inv_o, muldiv_inf_o,
                    muldiv_snan_o, muldiv_qnan_o, muldiv_anan_sign_o};

  // no ready while reset held
  a_rdy_in_reset: assert property (@(posedge clk) rst |-> !muldiv_rdy_o)
    else $error("ready high during reset");

  // flush empties the whole pipe on the next edge
  a_rdy_after_flush: assert property (@(posedge clk) disable iff (rst)
    $past(flush_i) |-> !muldiv_rdy_o)
    else $error("ready high on the edge after a flush");

  // start at an advancing edge, then 3 more advancing edges, no flush
  a_latency: assert property (@(posedge clk) disable iff (rst)
    ($past(start_i, 4) && $past(adv_i, 4) && $past(adv_i, 3) && $past(adv_i, 2)
     && $past(adv_i, 1) && !$past(flush_i, 4) && !$past(flush_i, 3)
     && !$past(flush_i, 2) && !$past(flush_i, 1)) |-> muldiv_rdy_o)
    else $error("no ready 4 advancing cycles after start");

  // stall freezes every output
  a_hold_on_stall: assert property (@(posedge clk) disable iff (rst)
    (!$past(adv_i) && !$past(flush_i)) |-> $stable(out_bus))
    else $error("outputs changed while adv_i was low");

endmodule

bind fpmul_top fpmul_props i_fpmul_props (
  .clk                (clk),
  .rst                (rst),
  .adv_i              (adv_i),
  .flush_i            (flush_i),
  .start_i            (start_i),
  .muldiv_rdy_o       (muldiv_rdy_o),
  .muldiv_sign_o      (muldiv_sign_o),
  .muldiv_shr_o       (muldiv_shr_o),
  .muldiv_exp10shr_o  (muldiv_exp10shr_o),
  .muldiv_exp10sh0_o  (muldiv_exp10sh0_o),
  .muldiv_fract28_o   (muldiv_fract28_o),
  .muldiv_inv_o       (muldiv_inv_o),
  .muldiv_inf_o       (muldiv_inf_o),
  .muldiv_snan_o      (muldiv_snan_o),
  .muldiv_qnan_o      (muldiv_qnan_o),
  .muldiv_anan_sign_o (muldiv_anan_sign_o)
);

`default_nettype wire

// File: bench/fpmul_tb.sv
// random multiply tests with fixed seed; inputs change on falling edges, outputs read there too
`timescale 1ns/100ps
`default_nettype none

`include "fpmul_settings.svh"

module fpmul_tb
  import fp_format_pkg::*, fpmul_pipe_pkg::*;
();

  localparam int          CLK_PERIOD  = 20;
  localparam int unsigned SEED        = 32'h656b_ba87;
  localparam int          N_OPS       = 500;
  localparam int          TIMEOUT_CYC = N_OPS * 8 + 200;

  // one expected result, due after a given count of advancing edges
  typedef struct {
    logic       sign;
    shr_t       shr;
    exp_t       exp10shr;
    exp_t       exp10sh0;
    fract_out_t fract;
    exc_flags_t flags;
    int         due;
  } expect_t;

  logic       clk;
  logic       rst;
  logic       adv_i;
  logic       flush_i;
  logic       start_i;
  logic       signa_i;
  exp_t       exp10a_i;
  fract_t     fract24a_i;
  logic       infa_i;
  logic       zeroa_i;
  logic       signb_i;
  exp_t       exp10b_i;
  fract_t     fract24b_i;
  logic       infb_i;
  logic       zerob_i;
  logic       snan_i;
  logic       qnan_i;
  logic       anan_sign_i;
  logic       muldiv_rdy_o;
  logic       muldiv_sign_o;
  shr_t       muldiv_shr_o;
  exp_t       muldiv_exp10shr_o;
  exp_t       muldiv_exp10sh0_o;
  fract_out_t muldiv_fract28_o;
  logic       muldiv_inv_o;
  logic       muldiv_inf_o;
  logic       muldiv_snan_o;
  logic       muldiv_qnan_o;
  logic       muldiv_anan_sign_o;

  expect_t pending_q[$];
  int      adv_cnt;
  logic    last_adv;
  logic    last_flush;
  int      mismatch_cnt;
  int      proto_cnt;

  fpmul_top i_fpmul_top (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // watchdog, generous bound on the whole run
  initial begin
    #(TIMEOUT_CYC * CLK_PERIOD);
    $display("Error: watchdog expired at %0t ns, results still outstanding", $time);
    $display("Simulation failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model
  ////////////////////////////////////////////////////////////////////////////

  // leading zeros from the msb, 0 for a zero fraction
  function automatic int count_lz(input fract_t f);
    int n;
    n = 0;
    while (n < `FPMUL_FRACT_W && f[`FPMUL_FRACT_W-1] == 1'b0) begin
      f = f << 1;
      n++;
    end
    if (n == `FPMUL_FRACT_W) n = 0;
    return n;
  endfunction

  function automatic expect_t model(input operand_t a, input operand_t b,
                                    input logic snan, input logic qnan, input logic asign);
    expect_t            e;
    int                 nlza;
    int                 nlzb;
    int                 s;
    int                 d;
    logic               fz;
    fract_t             na;
    fract_t             nb;
    exp_t               es;
    logic [47:0]        p;
    nlza = count_lz(a.fract);
    nlzb = count_lz(b.fract);
    fz   = a.zero | b.zero;
    na   = a.fract << nlza;
    nb   = b.fract << nlzb;
    s    = int'(a.exp) - nlza + int'(b.exp) - nlzb - `FPMUL_BIAS;
    es   = exp_t'(s);
    if (fz) begin
      na = '0;
      nb = '0;
      es = '0;
    end
    p = {24'd0, na} * {24'd0, nb};
    e.fract    = {p[47:21], |p[20:0]};
    e.sign     = a.sign ^ b.sign;
    e.exp10sh0 = es;
    // right-shift rule for the later align stage
    if (fz) begin
      e.shr      = '0;
      e.exp10shr = '0;
    end else if (es[`FPMUL_EXP_W-1]) begin
      d          = 1025 - int'(es);
      e.shr      = (d > 31) ? 5'd31 : shr_t'(d);
      e.exp10shr = 10'd1;
    end else begin
      e.shr      = (es == 10'd0) ? 5'd1 : 5'd0;
      e.exp10shr = (es == 10'd0) ? 10'd1 : es;
    end
    e.flags = '{inv: (a.zero & b.inf) | (b.zero & a.inf), inf: a.inf | b.inf,
                snan: snan, qnan: qnan, anan_sign: asign};
    e.due   = 0;
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_fract(input fract_out_t got, input fract_out_t want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: fract28 got %h expected %h", $time, got, want);
    end
  endtask

  task automatic check_exp(input string what, input exp_t got, input exp_t want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, what, got, want);
    end
  endtask

  task automatic check_shift(input shr_t got, input shr_t want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: shr got %0d expected %0d", $time, got, want);
    end
  endtask

  task automatic check_flags(input exc_flags_t got, input exc_flags_t want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: flags got %b expected %b", $time, got, want);
    end
  endtask

  task automatic check_sign(input logic got, input logic want);
    if (got !== want) begin
      mismatch_cnt++;
      $display("Mismatch at %0t ns: sign got %b expected %b", $time, got, want);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // result collection, run at the falling edge
  ////////////////////////////////////////////////////////////////////////////

  task automatic collect();
    expect_t    e;
    exc_flags_t got_f;
    if (last_flush) begin
      if (muldiv_rdy_o) begin
        proto_cnt++;
        $display("Error at %0t ns: ready high right after a flush", $time);
      end
    end else if (last_adv) begin
      if (pending_q.size() != 0 && pending_q[0].due == adv_cnt) begin
        e = pending_q.pop_front();
        if (!muldiv_rdy_o) begin
          proto_cnt++;
          $display("Error at %0t ns: ready missing for a started operation", $time);
        end else begin
          got_f = '{inv: muldiv_inv_o, inf: muldiv_inf_o, snan: muldiv_snan_o,
                    qnan: muldiv_qnan_o, anan_sign: muldiv_anan_sign_o};
          check_sign(muldiv_sign_o, e.sign);
          check_fract(muldiv_fract28_o, e.fract);
          check_shift(muldiv_shr_o, e.shr);
          check_exp("exp10shr", muldiv_exp10shr_o, e.exp10shr);
          check_exp("exp10sh0", muldiv_exp10sh0_o, e.exp10sh0);
          check_flags(got_f, e.flags);
        end
      end else if (muldiv_rdy_o) begin
        proto_cnt++;
        $display("Error at %0t ns: ready pulse with no result due", $time);
      end
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // stimulus
  ////////////////////////////////////////////////////////////////////////////

  // mix of normal, zero, inf, small-fraction and extreme-exponent operands
  task automatic make_operand(output operand_t op);
    logic [31:0] r;
    logic [31:0] r2;
    logic [31:0] k;
    r  = $urandom();
    r2 = $urandom();
    k  = $urandom_range(0, 9);
    op.sign = r[31];
    op.inf  = 1'b0;
    op.zero = 1'b0;
    op.exp  = {2'b00, r2[7:0]};
    case (k)
      0: begin
        // stale fraction bits behind the zero flag must be masked
        op.zero  = 1'b1;
        op.fract = r[23:0];
      end
      1: begin
        op.inf   = 1'b1;
        op.exp   = 10'd255;
        op.fract = 24'h80_0000;
      end
      // denormal-like, needs the leading-zero shift
      2: op.fract = {1'b0, r[22:0]} >> r[27:24];
      3: begin
        op.fract = {1'b1, r[22:0]};
        op.exp   = r2[8] ? 10'd1 : 10'd254;
      end
      default: op.fract = {1'b1, r[22:0]};
    endcase
  endtask

  // one clock: check last edge's result, then drive the next inputs
  task automatic step(input logic adv, input logic start, input logic flush);
    operand_t    a;
    operand_t    b;
    expect_t     e;
    logic [31:0] r;
    @(negedge clk);
    collect();
    make_operand(a);
    make_operand(b);
    r = $urandom();
    signa_i     = a.sign;
    exp10a_i    = a.exp;
    fract24a_i  = a.fract;
    infa_i      = a.inf;
    zeroa_i     = a.zero;
    signb_i     = b.sign;
    exp10b_i    = b.exp;
    fract24b_i  = b.fract;
    infb_i      = b.inf;
    zerob_i     = b.zero;
    snan_i      = r[0];
    qnan_i      = r[1];
    anan_sign_i = r[2];
    adv_i       = adv;
    start_i     = start;
    flush_i     = flush;
    // flushed work never comes out
    if (flush) pending_q.delete();
    if (adv) adv_cnt++;
    if (adv && start && !flush) begin
      e     = model(a, b, r[0], r[1], r[2]);
      e.due = adv_cnt + 3;
      pending_q.push_back(e);
    end
    last_adv   = adv;
    last_flush = flush;
  endtask

  task automatic run_phase(input int n_starts, input int stall_pct, input int start_pct,
                           input int flush_pct);
    int   issued;
    int   r_adv;
    int   r_start;
    int   r_flush;
    logic start;
    issued = 0;
    while (issued < n_starts) begin
      r_adv   = $urandom_range(0, 99);
      r_start = $urandom_range(0, 99);
      r_flush = $urandom_range(0, 99);
      start   = (r_start < start_pct);
      step(r_adv >= stall_pct, start, r_flush < flush_pct);
      if (start) issued++;
    end
  endtask

  initial begin
    void'($urandom(SEED));
    rst          = 1'b0;
    adv_i        = 1'b0;
    flush_i      = 1'b0;
    start_i      = 1'b0;
    signa_i      = 1'b0;
    exp10a_i     = '0;
    fract24a_i   = '0;
    infa_i       = 1'b0;
    zeroa_i      = 1'b0;
    signb_i      = 1'b0;
    exp10b_i     = '0;
    fract24b_i   = '0;
    infb_i       = 1'b0;
    zerob_i      = 1'b0;
    snan_i       = 1'b0;
    qnan_i       = 1'b0;
    anan_sign_i  = 1'b0;
    adv_cnt      = 0;
    last_adv     = 1'b0;
    last_flush   = 1'b0;
    mismatch_cnt = 0;
    proto_cnt    = 0;
    #1 rst = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // back to back at full rate
    run_phase(150, 0, 100, 0);
    // random stalls and gaps
    run_phase(200, 25, 60, 0);
    // stalls with occasional flushes
    run_phase(150, 20, 70, 4);
    while (pending_q.size() != 0) step(1'b1, 1'b0, 1'b0);
    // idle tail, no stray ready allowed
    repeat (6) step(1'b1, 1'b0, 1'b0);
    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, proto_cnt);
    if (mismatch_cnt == 0 && proto_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: fpmul.f
+incdir+hw
hw/fp_format_pkg.sv
hw/fpmul_pipe_pkg.sv
hw/fpmul_prod_if.sv
hw/fpmul_lzc.sv
hw/fpmul_stage_reg.sv
hw/fpmul_operand_prep.sv
hw/fpmul_product.sv
hw/fpmul_align_out.sv
hw/fpmul_top.sv
bench/fpmul_props.sv
bench/fpmul_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the fpmul testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module fpmul_tb -f fpmul.f -o fpmul_sim > build.log 2>&1; then
  cat build.log
  echo "ERROR: Verilator build failed, see build.log"
  exit 1
fi

./obj_dir/fpmul_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ "$sim_status" -ne 0 ]; then
  echo "ERROR: simulation exited with status $sim_status"
  exit 1
fi

if grep -q "^Simulation completed successfully$" sim.log; then
  exit 0
fi
echo "ERROR: pass message not found in sim.log"
exit 1
